/* filelist.f */
+incdir+include
src/pc_pkg.sv
src/pc_beta_ram.sv
src/pc_load_stage.sv
src/pc_layer_engine.sv
src/pc_unload_stage.sv
src/pc_encoder_top.sv
tests/pc_encoder_asserts.sv
tests/pc_encoder_tb.sv

/* Makefile */
# Verilator build and run for the polar encoder testbench.

VERILATOR ?= verilator
TOP       ?= pc_encoder_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= sim passed

SRCS    := $(wildcard src/*.sv) $(wildcard tests/*.sv) $(wildcard include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up as a line of its own.
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tests/pc_encoder_tb.sv */
// Polar encoder testbench
`timescale 1ns/1ps
`default_nettype none
`include "pc_macros.svh"

module pc_encoder_tb
  import pc_pkg::*;
();

  localparam int unsigned dat_w      = `PC_DAT_W;
  localparam int unsigned words      = 1 << `PC_WORDS_LOG2;    // Words per block.
  localparam int unsigned blk_bits   = dat_w * words;          // Bits per block, N.
  localparam int unsigned num_blocks = 48;                     // All blocks of the run, rounded up.
  localparam int unsigned wd_limit   = (num_blocks * 200 + 1000) * 10; // Watchdog limit in ns.
  localparam int unsigned one_pos [4] = '{0, 7, 8, 127};       // Single set bits for test 1.

  logic  iclk;
  logic  rst_n;
  logic  in_valid;
  logic  in_ready;
  word_t in_data;
  logic  out_valid;
  logic  out_ready = 1'b0;
  word_t out_data;
  logic  out_last;

  word_t       exp_q [$];  // Expected output words, oldest first.
  string       cur_test;   // Name used in error lines.
  int unsigned out_idx;    // Position of the next output word in its block.
  int unsigned chk_cnt;
  int unsigned err_cnt;
  int unsigned test_cnt;
  int unsigned test_chk0;  // Counts when the current test started.
  int unsigned test_err0;
  bit          stall_out;  // Random out_ready stalls when set.

  initial iclk = 1'b0;
  always #5 iclk = ~iclk; // 10 ns period.

  pc_encoder_top i_pc_encoder_top (
    .iclk     (iclk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (in_data),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data),
    .out_last (out_last)
  );

  // Reference transform, x_i is the XOR of every u_k whose index bits cover those of i.
  task automatic push_expected(input logic [blk_bits-1:0] u);
    logic [blk_bits-1:0] x;
    int unsigned         i;
    int unsigned         k;
    x = '0;
    for (i = 0; i < blk_bits; i++) begin
      for (k = 0; k < blk_bits; k++) begin
        if ((k & i) == i) begin
          x[i] = x[i] ^ u[k];
        end
      end
    end
    for (i = 0; i < words; i++) begin
      exp_q.push_back(x[dat_w*i +: dat_w]); // Word j holds bits 8j to 8j+7.
    end
  endtask

  function automatic logic [blk_bits-1:0] rand_block();
    logic [blk_bits-1:0] u;
    int unsigned         w;
    for (w = 0; w < blk_bits / 32; w++) begin
      u[32*w +: 32] = $urandom;
    end
    return u;
  endfunction

  // Starts and ends one cycle step after a rising edge.
  task automatic drive_block(input logic [blk_bits-1:0] u, input bit gaps,
                             input int unsigned n_words);
    int unsigned j;
    int unsigned idle;
    bit          xfer;
    for (j = 0; j < n_words; j++) begin
      if (gaps) begin
        idle = $urandom_range(0, 3); // Idle cycles before this word.
        repeat (idle) begin
          @(posedge iclk);
          #1;
        end
      end
      in_valid = 1'b1;
      in_data  = u[dat_w*j +: dat_w];
      xfer     = 1'b0;
      while (!xfer) begin
        @(negedge iclk);
        xfer = in_ready; // Settled mid-cycle, it decides the coming edge.
        @(posedge iclk);
        #1;
      end
      in_valid = 1'b0;
    end
  endtask

  task automatic send_block(input logic [blk_bits-1:0] u, input bit gaps);
    push_expected(u);
    drive_block(u, gaps, words);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge iclk);
    end
    @(posedge iclk); // Last word leaves on this edge.
    #1;
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_chk0 = chk_cnt;
    test_err0 = err_cnt;
  endtask

  task automatic end_test();
    test_cnt++;
    $display("Test %s finished: %0d checks, %0d errors", cur_test,
             chk_cnt - test_chk0, err_cnt - test_err0);
  endtask

  // Out_ready moves only just after an edge, so a random stall never splits a cycle.
  always @(posedge iclk) begin
    #1;
    if (stall_out) begin
      out_ready = ($urandom_range(0, 2) != 0);
    end else begin
      out_ready = 1'b1;
    end
  end

  // Outputs are sampled mid-cycle, where the handshake of the next edge is settled.
  always @(negedge iclk) begin
    word_t exp_w;
    if (!rst_n) begin
      out_idx = 0;
    end else if (out_valid && out_ready) begin
      chk_cnt += 2;
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("Unexpected output word %h in %s while no word was expected", out_data, cur_test);
      end else begin
        exp_w = exp_q.pop_front();
        if (out_data !== exp_w) begin
          err_cnt++;
          $display("Mismatch in %s word %0d: expected %h, actual %h", cur_test, out_idx,
                   exp_w, out_data);
        end
      end
      if (out_last !== (out_idx == words - 1)) begin
        err_cnt++;
        $display("Mismatch in %s out_last of word %0d: expected %0b, actual %0b", cur_test,
                 out_idx, (out_idx == words - 1), out_last);
      end
      out_idx = (out_idx + 1) % words;
    end
  end

  initial begin
    #(wd_limit);
    $display("Output stalled: run not finished after %0d ns, %0d words still expected",
             wd_limit, exp_q.size());
    $display("sim failed");
    $finish;
  end

  initial begin
    logic [blk_bits-1:0] u;
    int unsigned         b;
    void'($urandom(88));
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    stall_out = 1'b0;
    repeat (2) @(posedge iclk);
    #1;
    rst_n = 1'b1;

    start_test("directed");
    send_block('0, 1'b0); // Zero in, zero out.
    wait_drain();
    for (b = 0; b < 4; b++) begin
      u = '0;
      u[one_pos[b]] = 1'b1; // Output is 1 where the bits of i lie inside those of k.
      send_block(u, 1'b0);
      wait_drain();
    end
    end_test();

    start_test("single_random");
    send_block(rand_block(), 1'b0);
    wait_drain();
    end_test();

    start_test("input_gaps");
    for (b = 0; b < 20; b++) begin
      send_block(rand_block(), 1'b1); // Blocks queue up behind in_ready.
    end
    wait_drain();
    end_test();

    start_test("output_stalls");
    stall_out = 1'b1;
    for (b = 0; b < 20; b++) begin
      send_block(rand_block(), 1'b0);
    end
    wait_drain();
    stall_out = 1'b0;
    end_test();

    start_test("reset_mid_block");
    drive_block(rand_block(), 1'b0, 6); // Partial block, it never reaches the output.
    rst_n = 1'b0;
    @(negedge iclk);
    chk_cnt++;
    if (in_ready !== 1'b0 || out_valid !== 1'b0 || out_last !== 1'b0) begin
      err_cnt++;
      $display("Reset during loading left in_ready, out_valid or out_last high");
    end
    @(posedge iclk);
    #1;
    @(posedge iclk);
    #1;
    rst_n = 1'b1;
    send_block(rand_block(), 1'b0); // Waits for in_ready after the release.
    wait_drain();
    end_test();

    $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/pc_encoder_asserts.sv */
// Encoder handshake assertions
`timescale 1ns/1ps
`default_nettype none

module pc_encoder_asserts
  import pc_pkg::*;
(
  input logic  iclk,
  input logic  rst_n,
  input logic  in_ready,
  input logic  out_valid,
  input logic  out_ready,
  input word_t out_data,
  input logic  out_last
);

  // Control outputs stay quiet while reset is held.
  a_reset_quiet: assert property (@(posedge iclk) !rst_n |-> (!in_ready && !out_valid))
    else $error("in_ready or out_valid high during reset");

  // A stalled word stays put until the sink takes it.
  a_out_hold: assert property (@(posedge iclk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else $error("out_valid or out_data changed while out_ready was low");

  // Last marker rides on a valid word and stays with it through a stall.
  a_last_valid: assert property (@(posedge iclk) disable iff (!rst_n)
    (out_last && !out_ready) |=> (out_valid && out_last))
    else $error("out_last lost its valid word while out_ready was low");

endmodule

bind pc_encoder_top pc_encoder_asserts i_pc_encoder_asserts (
  .iclk     (iclk),
  .rst_n    (rst_n),
  .in_ready (in_ready),
  .out_valid(out_valid),
  .out_ready(out_ready),
  .out_data (out_data),
  .out_last (out_last)
);

`default_nettype wire

/* src/pc_encoder_top.sv */
// Polar block encoder top
`timescale 1ns/1ps
`default_nettype none

module pc_encoder_top
  import pc_pkg::*;
(
  input  logic  iclk,
  input  logic  rst_n,
  input  logic  in_valid,
  output logic  in_ready,
  input  word_t in_data,
  output logic  out_valid,
  input  logic  out_ready,
  output word_t out_data,
  output logic  out_last
);

  logic      ld_wr;       // Layout 0 write into RAM A.
  ram_addr_t ld_addr;
  logic      ld_sel;
  word_t     ld_data;
  logic      ld_done;     // Word 15 written.
  logic      calc_done;   // Final layer ready in RAM A.
  logic      ul_rd;
  ram_addr_t ul_addr;
  word_t     ul_rdat [2]; // Both banks of the row read by the unload stage.
  logic      ul_done;     // Block fully sent.

  pc_load_stage i_pc_load_stage (
    .iclk    (iclk),
    .rst_n   (rst_n),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_data (in_data),
    .ul_done (ul_done),
    .ld_wr   (ld_wr),
    .ld_addr (ld_addr),
    .ld_sel  (ld_sel),
    .ld_data (ld_data),
    .ld_done (ld_done)
  );

  pc_layer_engine i_pc_layer_engine (
    .iclk     (iclk),
    .rst_n    (rst_n),
    .ld_wr    (ld_wr),
    .ld_addr  (ld_addr),
    .ld_sel   (ld_sel),
    .ld_data  (ld_data),
    .ld_done  (ld_done),
    .calc_done(calc_done),
    .ul_rd    (ul_rd),
    .ul_addr  (ul_addr),
    .ul_rdat  (ul_rdat)
  );

  pc_unload_stage i_pc_unload_stage (
    .iclk     (iclk),
    .rst_n    (rst_n),
    .calc_done(calc_done),
    .ul_rd    (ul_rd),
    .ul_addr  (ul_addr),
    .ul_rdat  (ul_rdat),
    .out_valid(out_valid),
    .out_data (out_data),
    .out_last (out_last),
    .out_ready(out_ready),
    .ul_done  (ul_done)
  );

endmodule

`default_nettype wire

/* src/pc_unload_stage.sv */
// Polar encoder output stage
`timescale 1ns/1ps
`default_nettype none

module pc_unload_stage
  import pc_pkg::*;
(
  input  logic      iclk,
  input  logic      rst_n,
  input  logic      calc_done,
  output logic      ul_rd,
  output ram_addr_t ul_addr,
  input  word_t     ul_rdat [2],
  output logic      out_valid,
  output word_t     out_data,
  output logic      out_last,
  input  logic      out_ready,
  output logic      ul_done
);

  localparam int unsigned depth = pc_rd_lat + 2; // Enough to keep one read per cycle.
  localparam int unsigned ptr_w = $clog2(depth);
  localparam int unsigned cnt_w = $clog2(depth + 1);

  logic                 active;   // Reads still to issue for this block.
  word_idx_t            rd_idx;   // Next word to read.
  word_idx_t            pop_idx;  // Word at the head of the buffer.
  logic [pc_rd_lat-1:0] vld_sr;   // Reads in flight.
  logic [pc_rd_lat-1:0] sel_sr;   // Bank of each read in flight.
  logic [cnt_w-1:0]     avail;    // Free slots not yet promised to a read.
  logic [cnt_w-1:0]     fill;     // Words held in the buffer.
  word_t                fifo_mem [depth];
  logic [ptr_w-1:0]     wr_ptr;
  logic [ptr_w-1:0]     rd_ptr;
  logic                 push;
  logic                 pop;

  assign ul_rd     = active && (avail != '0); // A read only goes out with a slot behind it.
  assign ul_addr   = pc_layout_addr(0, rd_idx);
  assign push      = vld_sr[pc_rd_lat-1];
  assign out_valid = (fill != '0);
  assign out_data  = fifo_mem[rd_ptr]; // Head stays put while out_ready is low.
  assign out_last  = out_valid && (pop_idx == '1);
  assign pop       = out_valid && out_ready;

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      active  <= 1'b0;
      rd_idx  <= '0;
      pop_idx <= '0;
      vld_sr  <= '0;
      avail   <= cnt_w'(depth);
      fill    <= '0;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      ul_done <= 1'b0;
    end else begin
      vld_sr  <= (vld_sr << 1) | pc_rd_lat'(ul_rd);
      avail   <= avail - cnt_w'(ul_rd) + cnt_w'(pop);
      fill    <= fill + cnt_w'(push) - cnt_w'(pop);
      ul_done <= pop && out_last; // Word 15 has left.
      if (calc_done) begin
        active <= 1'b1;
      end else if (ul_rd && (rd_idx == '1)) begin
        active <= 1'b0; // All 16 reads issued.
      end
      if (ul_rd) begin
        rd_idx <= rd_idx + 1'b1;
      end
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr  <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
        pop_idx <= pop_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge iclk) begin
    sel_sr <= (sel_sr << 1) | pc_rd_lat'(pc_layout_bank(0, rd_idx)); // Bank follows the read.
    if (push) begin
      fifo_mem[wr_ptr] <= ul_rdat[sel_sr[pc_rd_lat-1]];
    end
  end

endmodule

`default_nettype wire

/* src/pc_layer_engine.sv */
// Polar cross-word layer engine
`timescale 1ns/1ps
`default_nettype none
`include "pc_macros.svh"

module pc_layer_engine
  import pc_pkg::*;
(
  input  logic      iclk,
  input  logic      rst_n,
  input  logic      ld_wr,
  input  ram_addr_t ld_addr,
  input  logic      ld_sel,
  input  word_t     ld_data,
  input  logic      ld_done,
  output logic      calc_done,
  input  logic      ul_rd,
  input  ram_addr_t ul_addr,
  output word_t     ul_rdat [2]
);

  localparam int unsigned nw_log2   = `PC_WORDS_LOG2;
  localparam int unsigned stage_len = (1 << nw_log2) + pc_rd_lat; // Cycles per stage.
  localparam int unsigned stg_w     = $clog2(nw_log2);

  typedef enum logic [1:0] {ph_load, ph_comp, ph_unload} phase_t;

  phase_t             phase;    // Which side owns RAM A.
  logic [nw_log2:0]   cnt;      // Cycle inside the current stage.
  logic [nw_log2:0]   wr_cnt;   // Cycle count seen from the write side.
  logic [stg_w-1:0]   stg;      // Cross-word stage, also the source layout.
  logic [pc_rd_lat-1:0] vld_sr; // Read-data valid, one bit per latency cycle.
  logic               hi_pend;  // Upper result goes out this cycle.
  word_t              hi_dat;   // Upper word held for its write.
  logic               comp;     // Compute phase.
  logic               rd_en;    // Datapath issues a pair read.
  ram_addr_t          dp_raddr; // Pair row being read.
  ram_addr_t          dp_pair;  // Pair row being written back.
  int unsigned        dst_lay;  // Layout the stage writes.
  word_t              src [2];  // Pair from the source RAM.
  logic               dp_wr;
  word_idx_t          dp_j;     // Word index of the result.
  word_t              dp_dat;
  logic               dp_sel;
  ram_addr_t          dp_waddr;
  logic               a_wr;
  logic               a_wsel;
  ram_addr_t          a_waddr;
  ram_addr_t          a_raddr;
  word_t              a_wdat;
  word_t              a_rdat [2];
  word_t              b_rdat [2];

  // Word index of one half of pair row a under layout k.
  function automatic word_idx_t pair_word(input int unsigned k, input ram_addr_t a,
                                          input logic hi);
    word_idx_t   j;
    int unsigned b;
    for (b = 0; b < nw_log2; b++) begin
      if (b < k) begin
        j[b] = a[b];
      end else if (b == k) begin
        j[b] = hi; // The pair bit itself.
      end else begin
        j[b] = a[b-1];
      end
    end
    return j;
  endfunction

  assign comp     = (phase == ph_comp);
  assign rd_en    = comp && (cnt < (1 << nw_log2)) && !cnt[0]; // One read every second cycle.
  assign dp_raddr = cnt[nw_log2-1:1];
  assign wr_cnt   = cnt - (nw_log2 + 1)'(pc_rd_lat);
  assign dp_pair  = wr_cnt[nw_log2-1:1]; // Same row for the lower and upper write.
  assign dst_lay  = (stg == stg_w'(nw_log2 - 1)) ? 0 : int'(stg) + 1;
  assign src[0]   = stg[0] ? b_rdat[0] : a_rdat[0]; // Even stages read A, odd stages read B.
  assign src[1]   = stg[0] ? b_rdat[1] : a_rdat[1];

  always_comb begin
    dp_wr = vld_sr[pc_rd_lat-1] | hi_pend;
    if (hi_pend) begin
      dp_j   = pair_word(stg, dp_pair, 1'b1);
      dp_dat = hi_dat; // Upper word passes through.
    end else begin
      dp_j   = pair_word(stg, dp_pair, 1'b0);
      dp_dat = src[0] ^ src[1]; // Lower word takes the XOR.
    end
    dp_sel   = pc_layout_bank(dst_lay, dp_j);
    dp_waddr = pc_layout_addr(dst_lay, dp_j);
  end

  // Load stage writes A outside compute; the unload stage reads it when it asks.
  assign a_wr    = comp ? (dp_wr & stg[0]) : ld_wr;
  assign a_waddr = comp ? dp_waddr : ld_addr;
  assign a_wsel  = comp ? dp_sel : ld_sel;
  assign a_wdat  = comp ? dp_dat : ld_data;
  assign a_raddr = ((phase == ph_unload) && ul_rd) ? ul_addr : dp_raddr;
  assign ul_rdat = a_rdat;

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      phase     <= ph_load;
      cnt       <= '0;
      stg       <= '0;
      vld_sr    <= '0;
      hi_pend   <= 1'b0;
      calc_done <= 1'b0;
    end else begin
      vld_sr    <= (vld_sr << 1) | pc_rd_lat'(rd_en);
      hi_pend   <= vld_sr[pc_rd_lat-1]; // Upper write trails the lower by one cycle.
      calc_done <= 1'b0;
      case (phase)
        ph_load: begin
          if (ld_done) begin
            phase <= ph_comp; // Word 15 is in A by the next cycle.
            cnt   <= '0;
            stg   <= '0;
          end
        end
        ph_comp: begin
          if (cnt == (nw_log2 + 1)'(stage_len - 1)) begin
            cnt <= '0;
            if (stg == stg_w'(nw_log2 - 1)) begin
              phase     <= ph_unload; // Final layer sits in A under layout 0.
              calc_done <= 1'b1;
            end else begin
              stg <= stg + 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          if (ld_wr) begin
            phase <= ph_load; // First word of the next block.
          end
        end
      endcase
    end
  end

  always_ff @(posedge iclk) begin
    hi_dat <= src[1];
  end

  pc_beta_ram #(
    .addr_w($bits(ram_addr_t)),
    .dat_w (`PC_DAT_W),
    .pipe  (`PC_RAM_PIPE)
  ) ram_a (
    .iclk (iclk),
    .write(a_wr),
    .waddr(a_waddr),
    .wsel (a_wsel),
    .wdat (a_wdat),
    .raddr(a_raddr),
    .rdat (a_rdat)
  );

  pc_beta_ram #(
    .addr_w($bits(ram_addr_t)),
    .dat_w (`PC_DAT_W),
    .pipe  (`PC_RAM_PIPE)
  ) ram_b (
    .iclk (iclk),
    .write(comp & dp_wr & ~stg[0]),
    .waddr(dp_waddr),
    .wsel (dp_sel),
    .wdat (dp_dat),
    .raddr(dp_raddr),
    .rdat (b_rdat)
  );

endmodule

`default_nettype wire

/* src/pc_load_stage.sv */
// Polar encoder input stage
`timescale 1ns/1ps
`default_nettype none

module pc_load_stage
  import pc_pkg::*;
(
  input  logic      iclk,
  input  logic      rst_n,
  input  logic      in_valid,
  output logic      in_ready,
  input  word_t     in_data,
  input  logic      ul_done,
  output logic      ld_wr,
  output ram_addr_t ld_addr,
  output logic      ld_sel,
  output word_t     ld_data,
  output logic      ld_done
);

  localparam int unsigned bf_stages = $clog2($bits(word_t)); // In-word butterfly stages.

  word_idx_t wcnt;     // Index of the next word in the block.
  logic      wait_ul;  // Block loaded, waiting for the output side to drain.
  logic      acc;      // Word accepted this cycle.
  logic      last_acc; // Word 15 accepted this cycle.
  word_t     bf;       // Word after the in-word butterflies.

  assign acc      = in_valid & in_ready;  // Transfer on the valid/ready handshake.
  assign last_acc = acc & (wcnt == '1);   // Final word of the block.

  // Bit i picks up bit i + 2^s whenever bit s of i is clear.
  always_comb begin
    int unsigned s;
    int unsigned i;
    bf = in_data;
    for (s = 0; s < bf_stages; s++) begin
      for (i = 0; i < $bits(word_t); i++) begin
        if (((i >> s) & 1) == 0) begin
          bf[i] = bf[i] ^ bf[i + (1 << s)]; // Upper bit of the pair is untouched.
        end
      end
    end
  end

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      wcnt     <= '0;
      wait_ul  <= 1'b0;
      in_ready <= 1'b0; // Rises one edge after reset is released.
      ld_wr    <= 1'b0;
      ld_done  <= 1'b0;
    end else begin
      ld_wr   <= acc;      // Each word is written the cycle after it arrives.
      ld_done <= last_acc; // Marks the write of word 15.
      if (acc) begin
        wcnt <= wcnt + 1'b1; // Wraps to 0 for the next block.
      end
      if (last_acc) begin
        wait_ul  <= 1'b1;
        in_ready <= 1'b0; // No overlap with compute or unload.
      end else if (ul_done) begin
        wait_ul  <= 1'b0;
        in_ready <= 1'b1;
      end else begin
        in_ready <= ~wait_ul;
      end
    end
  end

  always_ff @(posedge iclk) begin
    ld_data <= bf;
    ld_addr <= pc_layout_addr(0, wcnt); // Layout 0 pairs words that differ in bit 0.
    ld_sel  <= pc_layout_bank(0, wcnt);
  end

endmodule

`default_nettype wire

/* src/pc_beta_ram.sv */
// Two-bank beta RAM
`timescale 1ns/1ps
`default_nettype none

module pc_beta_ram #(
  parameter int addr_w = 3,
  parameter int dat_w  = 8,
  parameter bit pipe   = 0
) (
  input  logic              iclk,
  input  logic              write,
  input  logic [addr_w-1:0] waddr,
  input  logic              wsel,
  input  logic [dat_w-1:0]  wdat,
  input  logic [addr_w-1:0] raddr,
  output logic [dat_w-1:0]  rdat [2]
);

  logic [dat_w-1:0] bank0 [2**addr_w]; // Lower words of each pair.
  logic [dat_w-1:0] bank1 [2**addr_w]; // Upper words of each pair.
  logic [dat_w-1:0] rd_q  [2][2];      // Read stage 0 and the optional stage 1.

  always_ff @(posedge iclk) begin
    if (write) begin
      if (wsel) begin
        bank1[waddr] <= wdat; // Bank select picks the half of the row.
      end else begin
        bank0[waddr] <= wdat;
      end
    end
    rd_q[0][0] <= bank0[raddr]; // Both banks come back from one row.
    rd_q[0][1] <= bank1[raddr];
    rd_q[1]    <= rd_q[0];      // Extra register, only tapped when pipe is set.
  end

  assign rdat = rd_q[pipe]; // Read latency is 1 + pipe.

endmodule

`default_nettype wire

/* src/pc_pkg.sv */
// Polar encoder shared types
`default_nettype none

package pc_pkg;

  `include "pc_macros.svh"

  localparam int unsigned pc_rd_lat = 1 + `PC_RAM_PIPE; // Beta RAM read latency in cycles.

  typedef logic [`PC_DAT_W-1:0]        word_t;     // One block word.
  typedef logic [`PC_WORDS_LOG2-1:0]   word_idx_t; // Word position inside a block.
  typedef logic [`PC_WORDS_LOG2-2:0]   ram_addr_t; // Beta RAM row, one pair per row.

  // Bank of word j under layout s is the bit that separates a stage-s pair.
  function automatic logic pc_layout_bank(input int unsigned s, input word_idx_t j);
    return j[s]; // The lower word of each pair lands in bank 0.
  endfunction

  // Row of word j under layout s, with bit s squeezed out of the index.
  function automatic ram_addr_t pc_layout_addr(input int unsigned s, input word_idx_t j);
    ram_addr_t   a;
    int unsigned k;
    a = '0;
    for (k = 0; k < `PC_WORDS_LOG2 - 1; k++) begin
      if (k < s) begin
        a[k] = j[k];   // Bits below s keep their place.
      end else begin
        a[k] = j[k+1]; // Bits above s move down by one.
      end
    end
    return a;
  endfunction

endpackage

`default_nettype wire

/* include/pc_macros.svh */
// Polar encoder build options
`ifndef PC_MACROS_SVH
`define PC_MACROS_SVH

// Bits per data word; the in-word butterflies span all of them.
`define PC_DAT_W 8

// Log2 of words per block, which is also the number of cross-word stages.
`define PC_WORDS_LOG2 4

// Set to 1 for a second beta RAM read register; read latency is 1 + this value.
`define PC_RAM_PIPE 0

`endif
